//--- src/motorPwmPkg.sv
package motorPwmPkg;

    // pwm period and duty width, in clock cycles
    localparam int PERIOD_W = 12;

    // per-step accumulators and loss report
    localparam int ACC_W = 16;

    // electrical steps in one full cycle
    localparam int STEP_COUNT = 12;

    // phase weight per step, in sixteenths of the amplitude
    localparam logic [4:0] stepWeight [0:STEP_COUNT-1] = '{
        5'd0, 5'd4, 5'd8, 5'd11, 5'd14, 5'd16,
        5'd16, 5'd14, 5'd11, 5'd8, 5'd4, 5'd0
    };

    typedef enum logic {
        DIR_FWD = 1'b0,
        DIR_REV = 1'b1
    } dirE;

    typedef enum logic {
        SEQ_IDLE = 1'b0,
        SEQ_RUN  = 1'b1
    } seqStateE;

endpackage

//--- src/stepSequencer.sv
module stepSequencer
    import motorPwmPkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  logic       run,
    input  dirE        dir,
    input  logic [7:0] stepPeriods,
    input  logic       periodStart,
    output logic       active,
    output logic       stepFirst,
    output logic       lastPeriod,
    output logic [3:0] step
);

    seqStateE   state;
    // periods started so far in the current step and zero before the first one of a run
    logic [7:0] periodCnt;
    logic [7:0] periodCntNext;
    logic       stepDone;
    logic [3:0] stepNext;

    assign active = (state == SEQ_RUN);

    // every period of the current step has already started
    assign stepDone = (periodCnt == stepPeriods);

    assign periodCntNext = stepDone ? 8'd1 : periodCnt + 8'd1;

    // the first periodStart of a run also opens a step
    assign stepFirst = active && periodStart && (stepDone || periodCnt == 8'd0);

    // covers the periodStart cycle of the final period as well
    assign lastPeriod = active && (periodStart ? (periodCntNext == stepPeriods) : stepDone);

    // wrap modulo the electrical cycle in both directions
    always_comb begin
        if (dir == DIR_REV) begin
            stepNext = (step == 4'd0) ? 4'(STEP_COUNT - 1) : step - 4'd1;
        end else begin
            stepNext = (step == 4'(STEP_COUNT - 1)) ? 4'd0 : step + 4'd1;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= SEQ_IDLE;
            periodCnt <= '0;
            step      <= '0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    periodCnt <= '0;
                    step      <= '0;
                    if (run) begin
                        state <= SEQ_RUN;
                    end
                end
                SEQ_RUN: begin
                    if (!run) begin
                        state     <= SEQ_IDLE;
                        periodCnt <= '0;
                        step      <= '0;
                    end else if (periodStart) begin
                        periodCnt <= periodCntNext;
                        if (stepDone) begin
                            step <= stepNext;
                        end
                    end
                end
                default: begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

    // step never leaves the 12-entry weight table
    assert property (@(posedge clk) disable iff (!rstN) step < 4'(STEP_COUNT));

endmodule

//--- src/pwmPeriodTimer.sv
module pwmPeriodTimer
    import motorPwmPkg::*;
(
    input  logic                clk,
    input  logic                rstN,
    input  logic                active,
    input  logic [PERIOD_W-1:0] pwmPeriod,
    output logic                periodStart
);

    logic [PERIOD_W-1:0] cnt;

    // strobe on the cycle the count reaches one
    assign periodStart = active && (cnt == PERIOD_W'(1));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cnt <= PERIOD_W'(2);
        end else if (!active) begin
            // preset so the first strobe falls one cycle after active rises
            cnt <= PERIOD_W'(2);
        end else if (periodStart) begin
            cnt <= pwmPeriod;
        end else begin
            cnt <= cnt - PERIOD_W'(1);
        end
    end

    // consecutive strobes are never back to back
    assert property (@(posedge clk) disable iff (!rstN)
        periodStart |=> !periodStart);

endmodule

//--- src/dutyTable.sv
module dutyTable
    import motorPwmPkg::*;
(
    input  logic                clk,
    input  logic                rstN,
    input  logic [3:0]          step,
    input  logic [PERIOD_W-1:0] amplitude,
    output logic [PERIOD_W-1:0] dutyA,
    output logic [PERIOD_W-1:0] dutyB,
    output logic [PERIOD_W-1:0] dutyC
);

    logic [3:0] idxB;
    logic [3:0] idxC;

    // amplitude * weight / 16, truncated; full weight gives the amplitude back
    function automatic logic [PERIOD_W-1:0] scaleDuty(
        input logic [3:0]          idx,
        input logic [PERIOD_W-1:0] amp
    );
        logic [PERIOD_W+4:0] product;
        product = amp * stepWeight[idx];
        return product[PERIOD_W+3:4];
    endfunction

    // phase B sits 4 steps ahead
    assign idxB = (step >= 4'd8) ? step - 4'd8 : step + 4'd4;
    // phase C sits 8 steps ahead
    assign idxC = (step >= 4'd4) ? step - 4'd4 : step + 4'd8;

    // reloaded every cycle so a new step shows up one cycle after step moves
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            dutyA <= '0;
            dutyB <= '0;
            dutyC <= '0;
        end else begin
            dutyA <= scaleDuty(step, amplitude);
            dutyB <= scaleDuty(idxB, amplitude);
            dutyC <= scaleDuty(idxC, amplitude);
        end
    end

endmodule

//--- src/phasePulseGen.sv
module phasePulseGen
    import motorPwmPkg::*;
#(
    parameter int MIN_PULSE = 32
) (
    input  logic                clk,
    input  logic                rstN,
    input  logic                active,
    input  logic                periodStart,
    input  logic                lastPeriod,
    input  logic [PERIOD_W-1:0] duty,
    input  logic [PERIOD_W-1:0] pwmPeriod,
    output logic                pwm
);

    // duty carried over from periods that were too short to drive
    logic [PERIOD_W-1:0] remainder;
    logic [PERIOD_W-1:0] pulseCnt;
    logic [PERIOD_W:0]   sum;
    logic [PERIOD_W-1:0] clipLimit;
    logic [PERIOD_W-1:0] pulseLen;
    logic                fire;

    assign sum = {1'b0, remainder} + {1'b0, duty};

    // the final period of a step flushes whatever is left
    assign fire = (sum >= (PERIOD_W + 1)'(MIN_PULSE)) || lastPeriod;

    // keep at least one low cycle before the next period
    assign clipLimit = pwmPeriod - PERIOD_W'(1);

    always_comb begin
        if (sum > {1'b0, clipLimit}) begin
            pulseLen = clipLimit;
        end else begin
            pulseLen = sum[PERIOD_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            remainder <= '0;
            pulseCnt  <= '0;
        end else if (!active) begin
            remainder <= '0;
            pulseCnt  <= '0;
        end else if (periodStart) begin
            if (fire) begin
                remainder <= '0;
                pulseCnt  <= pulseLen;
            end else begin
                // below MIN_PULSE here, so it fits the duty width
                remainder <= sum[PERIOD_W-1:0];
                pulseCnt  <= '0;
            end
        end else if (pulseCnt != '0) begin
            pulseCnt <= pulseCnt - PERIOD_W'(1);
        end
    end

    // high for exactly pulseLen cycles, starting the cycle after periodStart
    assign pwm = active && (pulseCnt != '0);

    // clipping against the timer period leaves no pulse running into the next one
    assert property (@(posedge clk) disable iff (!rstN)
        periodStart |-> (pulseCnt == '0));

endmodule

//--- src/lossMonitor.sv
module lossMonitor
    import motorPwmPkg::*;
(
    input  logic                clk,
    input  logic                rstN,
    input  logic                active,
    input  logic                periodStart,
    input  logic                stepFirst,
    input  logic [PERIOD_W-1:0] dutyA,
    input  logic [PERIOD_W-1:0] dutyB,
    input  logic [PERIOD_W-1:0] dutyC,
    input  logic                pwmA,
    input  logic                pwmB,
    input  logic                pwmC,
    output logic                lossValid,
    output logic [ACC_W-1:0]    lossA,
    output logic [ACC_W-1:0]    lossB,
    output logic [ACC_W-1:0]    lossC
);

    // index 0, 1, 2 is phase A, B, C
    logic [2:0][PERIOD_W-1:0] dutyV;
    logic [2:0]               pwmV;
    logic [2:0][ACC_W-1:0]    wantAcc;
    logic [2:0][ACC_W-1:0]    realAcc;
    logic [2:0][ACC_W-1:0]    lossQ;
    // a full step has been accumulated in this run
    logic                     firstSeen;

    function automatic logic [ACC_W-1:0] absDiff(
        input logic [ACC_W-1:0] a,
        input logic [ACC_W-1:0] b
    );
        return (a >= b) ? a - b : b - a;
    endfunction

    assign dutyV = {dutyC, dutyB, dutyA};
    assign pwmV  = {pwmC, pwmB, pwmA};

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            firstSeen <= 1'b0;
            lossValid <= 1'b0;
            wantAcc   <= '0;
            realAcc   <= '0;
            lossQ     <= '0;
        end else if (!active) begin
            firstSeen <= 1'b0;
            lossValid <= 1'b0;
            wantAcc   <= '0;
            realAcc   <= '0;
        end else begin
            lossValid <= stepFirst && firstSeen;
            if (stepFirst) begin
                firstSeen <= 1'b1;
            end
            for (int i = 0; i < 3; i++) begin
                if (stepFirst) begin
                    if (firstSeen) begin
                        lossQ[i] <= absDiff(wantAcc[i], realAcc[i]);
                    end
                    // new step starts with this period's duty
                    wantAcc[i] <= ACC_W'(dutyV[i]);
                    realAcc[i] <= ACC_W'(pwmV[i]);
                end else begin
                    if (periodStart) begin
                        wantAcc[i] <= wantAcc[i] + ACC_W'(dutyV[i]);
                    end
                    if (pwmV[i]) begin
                        realAcc[i] <= realAcc[i] + ACC_W'(1);
                    end
                end
            end
        end
    end

    assign lossA = lossQ[0];
    assign lossB = lossQ[1];
    assign lossC = lossQ[2];

endmodule

//--- src/motorPwmTop.sv
module motorPwmTop
    import motorPwmPkg::*;
#(
    parameter int MIN_PULSE = 32
) (
    input  logic                clk,
    input  logic                rstN,
    input  logic                run,
    input  dirE                 dir,
    input  logic [PERIOD_W-1:0] pwmPeriod,
    input  logic [7:0]          stepPeriods,
    input  logic [PERIOD_W-1:0] amplitude,
    output logic                pwmA,
    output logic                pwmB,
    output logic                pwmC,
    output logic [3:0]          step,
    output logic                lossValid,
    output logic [ACC_W-1:0]    lossA,
    output logic [ACC_W-1:0]    lossB,
    output logic [ACC_W-1:0]    lossC
);

    logic                active;
    logic                periodStart;
    logic                stepFirst;
    logic                lastPeriod;
    logic [PERIOD_W-1:0] dutyA;
    logic [PERIOD_W-1:0] dutyB;
    logic [PERIOD_W-1:0] dutyC;

    stepSequencer i_stepSequencer (
        .clk         (clk),
        .rstN        (rstN),
        .run         (run),
        .dir         (dir),
        .stepPeriods (stepPeriods),
        .periodStart (periodStart),
        .active      (active),
        .stepFirst   (stepFirst),
        .lastPeriod  (lastPeriod),
        .step        (step)
    );

    pwmPeriodTimer i_pwmPeriodTimer (
        .clk         (clk),
        .rstN        (rstN),
        .active      (active),
        .pwmPeriod   (pwmPeriod),
        .periodStart (periodStart)
    );

    dutyTable i_dutyTable (
        .clk       (clk),
        .rstN      (rstN),
        .step      (step),
        .amplitude (amplitude),
        .dutyA     (dutyA),
        .dutyB     (dutyB),
        .dutyC     (dutyC)
    );

    phasePulseGen #(.MIN_PULSE(MIN_PULSE)) i_pulseA (
        .clk         (clk),
        .rstN        (rstN),
        .active      (active),
        .periodStart (periodStart),
        .lastPeriod  (lastPeriod),
        .duty        (dutyA),
        .pwmPeriod   (pwmPeriod),
        .pwm         (pwmA)
    );

    phasePulseGen #(.MIN_PULSE(MIN_PULSE)) i_pulseB (
        .clk         (clk),
        .rstN        (rstN),
        .active      (active),
        .periodStart (periodStart),
        .lastPeriod  (lastPeriod),
        .duty        (dutyB),
        .pwmPeriod   (pwmPeriod),
        .pwm         (pwmB)
    );

    phasePulseGen #(.MIN_PULSE(MIN_PULSE)) i_pulseC (
        .clk         (clk),
        .rstN        (rstN),
        .active      (active),
        .periodStart (periodStart),
        .lastPeriod  (lastPeriod),
        .duty        (dutyC),
        .pwmPeriod   (pwmPeriod),
        .pwm         (pwmC)
    );

    lossMonitor i_lossMonitor (
        .clk         (clk),
        .rstN        (rstN),
        .active      (active),
        .periodStart (periodStart),
        .stepFirst   (stepFirst),
        .dutyA       (dutyA),
        .dutyB       (dutyB),
        .dutyC       (dutyC),
        .pwmA        (pwmA),
        .pwmB        (pwmB),
        .pwmC        (pwmC),
        .lossValid   (lossValid),
        .lossA       (lossA),
        .lossB       (lossB),
        .lossC       (lossC)
    );

endmodule

//--- tb/motorPwmTb.sv
module motorPwmTb
    import motorPwmPkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MIN_PULSE = 32;

    logic                     clk = 1'b0;
    logic                     rstN;
    logic                     run;
    dirE                      dir;
    logic [PERIOD_W-1:0]      pwmPeriod;
    logic [7:0]               stepPeriods;
    logic [PERIOD_W-1:0]      amplitude;
    logic                     pwmA;
    logic                     pwmB;
    logic                     pwmC;
    logic [3:0]               step;
    logic                     lossValid;
    logic [ACC_W-1:0]         lossA;
    logic [ACC_W-1:0]         lossB;
    logic [ACC_W-1:0]         lossC;
    logic [2:0]               pwmV;
    logic [2:0][ACC_W-1:0]    lossV;

    // phase weights in sixteenths per electrical step
    int phaseWeight [0:11] = '{0, 4, 8, 11, 14, 16, 16, 14, 11, 8, 4, 0};
    // expected pulses per phase, losses per step and step values for the current run
    int pulseMem [0:2][0:255];
    int pulseWr [0:2];
    int pulseRd [0:2];
    int lossMem [0:2][0:63];
    int stepMem [0:63];
    int stepWr;
    int stepRd;
    // monitor state
    int runLen [0:2];
    int sinceChange;
    int stepChanges;
    int stepCycles;
    logic [3:0] lastStep;
    bit checking;
    bit timedOut;
    int checkCount;
    int errorCount;
    int errBase;
    logic [31:0] rngState;

    always #4 clk = ~clk;

    motorPwmTop #(.MIN_PULSE(MIN_PULSE)) i_motorPwmTop (.*);

    assign pwmV  = {pwmC, pwmB, pwmA};
    assign lossV = {lossC, lossB, lossA};

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic string phaseName(input int ph);
        return (ph == 0) ? "A" : (ph == 1) ? "B" : "C";
    endfunction

    // B leads A by 4 steps, C by 8
    function automatic int phaseDuty(input int stepIdx, input int ph, input int amp);
        return amp * phaseWeight[(stepIdx + 4 * ph) % 12] / 16;
    endfunction

    // pulse length of one PWM period with the carried remainder updated in place
    function automatic int periodPulse(input int duty, input bit last, input int period,
                                       inout int rem);
        int sum;
        sum = rem + duty;
        if (sum < MIN_PULSE && !last) begin
            rem = sum;
            return 0;
        end
        rem = 0;
        return (sum > period - 1) ? period - 1 : sum;
    endfunction

    // per-step loss of one phase and the nonzero pulses it queues for the monitor
    function automatic int stepLoss(input int ph, input int dFirst, input int dRest,
                                    input int periods, input int period);
        int rem;
        int duty;
        int len;
        int want;
        int driven;
        rem = 0;
        want = 0;
        driven = 0;
        for (int k = 0; k < periods; k++) begin
            // the first period still runs on the previous step's duty
            duty = (k == 0) ? dFirst : dRest;
            len = periodPulse(duty, k == periods - 1, period, rem);
            want += duty;
            driven += len;
            if (len != 0) begin
                pulseMem[ph][pulseWr[ph]] = len;
                pulseWr[ph]++;
            end
        end
        return (want > driven) ? want - driven : driven - want;
    endfunction

    task automatic buildExpected(input dirE d, input int amp, input int period,
                                 input int periods, input int nSteps);
        int cur;
        int prev;
        cur = 0;
        prev = 0;
        stepRd = 0;
        stepWr = nSteps;
        for (int ph = 0; ph < 3; ph++) begin
            pulseWr[ph] = 0;
            pulseRd[ph] = 0;
        end
        for (int s = 0; s < nSteps; s++) begin
            for (int ph = 0; ph < 3; ph++) begin
                lossMem[ph][s] = stepLoss(ph, phaseDuty(prev, ph, amp),
                                          phaseDuty(cur, ph, amp), periods, period);
            end
            prev = cur;
            cur = (d == DIR_REV) ? (cur + 11) % 12 : (cur + 1) % 12;
            stepMem[s] = cur;
        end
    endtask

    task automatic checkPulse(input string name, input logic [PERIOD_W-1:0] got,
                              input logic [PERIOD_W-1:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic checkLoss(input string name, input logic [ACC_W-1:0] got,
                             input logic [ACC_W-1:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic checkStep(input string name, input logic [3:0] got, input logic [3:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic checkIdle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            checkStep("step", step, 4'd0);
            checkBit("pwmA", pwmA, 1'b0);
            checkBit("pwmB", pwmB, 1'b0);
            checkBit("pwmC", pwmC, 1'b0);
            checkBit("lossValid", lossValid, 1'b0);
        end
    endtask

    // runs nSteps full steps, then drops run early in the next one
    task automatic runMotor(input dirE d, input int amp, input int period,
                            input int periods, input int nSteps);
        int waited;
        if (timedOut) begin
            return;
        end
        buildExpected(d, amp, period, periods, nSteps);
        stepCycles = period * periods;
        @(posedge clk);
        dir <= d;
        amplitude <= PERIOD_W'(amp);
        pwmPeriod <= PERIOD_W'(period);
        stepPeriods <= 8'(periods);
        @(posedge clk);
        run <= 1'b1;
        stepChanges = 0;
        checking = 1'b1;
        waited = 0;
        while (stepChanges < nSteps && waited < (nSteps + 2) * stepCycles) begin
            @(posedge clk);
            waited++;
        end
        checking = 1'b0;
        run <= 1'b0;
        if (stepChanges < nSteps) begin
            timedOut = 1'b1;
            errorCount++;
            $display("timeout with %0d of %0d step changes seen", stepChanges, nSteps);
            return;
        end
        for (int ph = 0; ph < 3; ph++) begin
            if (pulseRd[ph] != pulseWr[ph]) begin
                errorCount++;
                $display("%0d expected pulses on pwm%s never came",
                         pulseWr[ph] - pulseRd[ph], phaseName(ph));
            end
        end
        waited = 0;
        while ((step != 4'd0 || pwmA || pwmB || pwmC) && waited < 16) begin
            @(negedge clk);
            waited++;
        end
        checkIdle(8);
    endtask

    task automatic reportTest(input int num, input string name);
        if (errorCount == errBase) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errorCount - errBase);
        end
    endtask

    // pulses are compared as they end, losses and step values as each step shows up
    always @(negedge clk) begin
        if (!checking) begin
            for (int ph = 0; ph < 3; ph++) begin
                runLen[ph] = 0;
            end
            sinceChange = 0;
            lastStep = 4'd0;
        end else begin
            sinceChange++;
            if (step !== lastStep) begin
                stepChanges++;
                if (stepRd < stepWr) begin
                    checkStep("step", step, 4'(stepMem[stepRd]));
                    // offset of the first step from run is not visible here
                    if (stepChanges > 1) begin
                        checkCount++;
                        if (sinceChange != stepCycles) begin
                            errorCount++;
                            $display("step %0d began after %0d cycles instead of %0d",
                                     step, sinceChange, stepCycles);
                        end
                    end
                    checkBit("lossValid", lossValid, 1'b1);
                    for (int ph = 0; ph < 3; ph++) begin
                        checkLoss({"loss", phaseName(ph)}, lossV[ph],
                                  ACC_W'(lossMem[ph][stepRd]));
                    end
                    stepRd++;
                end else begin
                    errorCount++;
                    $display("step moved to %0d with no change expected", step);
                end
                sinceChange = 0;
                lastStep = step;
            end else begin
                checkBit("lossValid", lossValid, 1'b0);
            end
            for (int ph = 0; ph < 3; ph++) begin
                if (pwmV[ph]) begin
                    runLen[ph]++;
                end else if (runLen[ph] != 0) begin
                    if (pulseRd[ph] < pulseWr[ph]) begin
                        checkPulse({"pwm", phaseName(ph)}, PERIOD_W'(runLen[ph]),
                                   PERIOD_W'(pulseMem[ph][pulseRd[ph]]));
                        pulseRd[ph]++;
                    end else begin
                        errorCount++;
                        $display("unexpected %0d-cycle pulse on pwm%s", runLen[ph], phaseName(ph));
                    end
                    runLen[ph] = 0;
                end
            end
        end
    end

    initial begin
        rstN = 1'b0;
        run = 1'b0;
        dir = DIR_FWD;
        pwmPeriod = PERIOD_W'(100);
        stepPeriods = 8'd2;
        amplitude = '0;
        checking = 1'b0;
        timedOut = 1'b0;
        checkCount = 0;
        errorCount = 0;
        stepChanges = 0;
        stepRd = 0;
        stepWr = 0;
        rngState = 32'h220344eb;
        repeat (10) @(posedge clk);
        rstN <= 1'b1;

        errBase = errorCount;
        checkIdle(20);
        reportTest(1, "idle after reset");

        rngState = xorshift(rngState);
        errBase = errorCount;
        runMotor(DIR_FWD, 120 + int'(rngState % 60), 200, 3, 13);
        reportTest(2, "large amplitude, forward with wrap");

        // most duties of 0 to 40 cycles fall below the minimum pulse
        errBase = errorCount;
        runMotor(DIR_REV, 40, 100, 4, 12);
        reportTest(3, "small amplitude, skipped and merged pulses");

        rngState = xorshift(rngState);
        errBase = errorCount;
        runMotor(DIR_FWD, 900 + int'(rngState % 200), MIN_PULSE + 2, 2, 6);
        reportTest(4, "clipping at a short period");

        errBase = errorCount;
        runMotor(DIR_REV, 300, 80, 2, 13);
        reportTest(5, "reverse direction with wrap");

        errBase = errorCount;
        runMotor(DIR_FWD, 600, 150, 3, 1);
        runMotor(DIR_FWD, 600, 150, 3, 2);
        reportTest(6, "stop mid-step and restart");

        $display("6 tests, %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- files.f
src/motorPwmPkg.sv
src/stepSequencer.sv
src/pwmPeriodTimer.sv
src/dutyTable.sv
src/phasePulseGen.sv
src/lossMonitor.sv
src/motorPwmTop.sv
tb/motorPwmTb.sv
